//--- rtl/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;
  localparam int BYTES_PER_WORD = WORD_W / 8;

  // Peripheral region when this address bit is set
  localparam int UNCACHED_BIT = 31;

  // Byte address on every bus
  typedef logic [ADDR_W-1:0] addr_t;

  // Core and peripheral data word
  typedef logic [WORD_W-1:0] word_t;

  // One enable per byte lane
  typedef logic [BYTES_PER_WORD-1:0] byteen_t;

endpackage

`default_nettype wire

//--- rtl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  // Direct-mapped geometry
  localparam int LINE_WORDS = 4;
  localparam int NUM_LINES = 64;

  // Address slicing, low to high: byte, word select, index, tag
  localparam int WORD_SEL_LSB = $clog2(mem_map_pkg::BYTES_PER_WORD);
  localparam int WORD_SEL_W = $clog2(LINE_WORDS);
  localparam int INDEX_LSB = WORD_SEL_LSB + WORD_SEL_W;
  localparam int INDEX_W = $clog2(NUM_LINES);
  localparam int TAG_LSB = INDEX_LSB + INDEX_W;
  // Tag stops below the region bit, uncached addresses never live here
  localparam int TAG_W = mem_map_pkg::UNCACHED_BIT - TAG_LSB;

  // Cycles of memory silence before a miss gives up
  localparam int FILL_TIMEOUT = 4;

  typedef mem_map_pkg::word_t [LINE_WORDS-1:0] line_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [WORD_SEL_W-1:0] word_sel_t;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_TAG_LOOKUP,
    SEQ_ISSUE,
    SEQ_STORE_MISS,
    SEQ_LOAD_MISS
  } seq_state_t;

endpackage

`default_nettype wire

//--- rtl/dcache_array.sv
`default_nettype none

module dcache_array (
  input  wire logic                 clk,
  input  wire logic                 resetn,
  input  mem_map_pkg::addr_t        lookup_address,
  output logic                      hit,
  output dcache_pkg::line_t         read_line,
  input  wire logic                 word_we,
  input  mem_map_pkg::addr_t        word_address,
  input  mem_map_pkg::word_t        word_data,
  input  mem_map_pkg::byteen_t      word_byteen,
  input  wire logic                 fill_we,
  input  mem_map_pkg::addr_t        fill_address,
  input  dcache_pkg::line_t         fill_data
);

  // Line, tag and valid storage
  dcache_pkg::line_t lines [dcache_pkg::NUM_LINES];
  dcache_pkg::tag_t tags [dcache_pkg::NUM_LINES];
  logic [dcache_pkg::NUM_LINES-1:0] valid;

  dcache_pkg::index_t lookup_index_r;
  dcache_pkg::tag_t lookup_tag_r;

  dcache_pkg::index_t fill_index;
  dcache_pkg::tag_t fill_tag;
  dcache_pkg::index_t word_index;
  dcache_pkg::word_sel_t word_sel;

  assign fill_index = fill_address[dcache_pkg::INDEX_LSB +: dcache_pkg::INDEX_W];
  assign fill_tag = fill_address[dcache_pkg::TAG_LSB +: dcache_pkg::TAG_W];
  assign word_index = word_address[dcache_pkg::INDEX_LSB +: dcache_pkg::INDEX_W];
  assign word_sel = word_address[dcache_pkg::WORD_SEL_LSB +: dcache_pkg::WORD_SEL_W];

  // Lookup address captured once per cycle, compared in the next
  always_ff @(posedge clk)
  begin
    lookup_index_r <= lookup_address[dcache_pkg::INDEX_LSB +: dcache_pkg::INDEX_W];
    lookup_tag_r <= lookup_address[dcache_pkg::TAG_LSB +: dcache_pkg::TAG_W];
  end

  // Array contents seen as they stand, so a fill shows up right away
  assign hit = valid[lookup_index_r] && (tags[lookup_index_r] == lookup_tag_r);
  assign read_line = lines[lookup_index_r];

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      valid <= '0;
    end
    else if (fill_we)
    begin
      valid[fill_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fill_we)
    begin
      lines[fill_index] <= fill_data;
      tags[fill_index] <= fill_tag;
    end
    // Store hit merges only the enabled lanes of one word
    if (word_we)
    begin
      for (int b = 0; b < mem_map_pkg::BYTES_PER_WORD; b++)
      begin
        if (word_byteen[b])
        begin
          lines[word_index][word_sel][8*b +: 8] <= word_data[8*b +: 8];
        end
      end
    end
  end

  // Memory fills and core store hits must not collide on a line
  fill_store_apart: assert property (
    @(posedge clk) disable iff (!resetn)
    !(fill_we && word_we && (fill_index == word_index))
  )
  else $error("fill and word write hit line %0d in the same cycle", fill_index);

endmodule

`default_nettype wire

//--- rtl/miss_sequencer.sv
`default_nettype none

module miss_sequencer (
  input  wire logic                 clk,
  input  wire logic                 resetn,
  input  wire logic                 cpu_en,
  input  wire logic                 cpu_wren,
  input  mem_map_pkg::addr_t        cpu_address,
  input  mem_map_pkg::word_t        cpu_writedata,
  input  mem_map_pkg::byteen_t      cpu_byteen,
  input  wire logic                 hit,
  output logic                      mem_en,
  input  wire logic                 mem_wait,
  output logic                      word_we,
  output mem_map_pkg::word_t        word_data,
  output mem_map_pkg::byteen_t      word_byteen,
  output logic                      cached_wait
);

  dcache_pkg::seq_state_t state;
  dcache_pkg::seq_state_t state_next;

  logic cached_req;
  logic issued_r;
  logic [dcache_pkg::FILL_TIMEOUT-1:0] timeout_sr;
  logic timed_out;

  assign cached_req = cpu_en && !cpu_address[mem_map_pkg::UNCACHED_BIT];
  assign timed_out = (timeout_sr == '0);

  // Tag check takes a cycle, so the store payload waits one cycle too
  always_ff @(posedge clk)
  begin
    word_data <= cpu_writedata;
    word_byteen <= cpu_byteen;
  end

  assign word_we = (state == dcache_pkg::SEQ_TAG_LOOKUP) && cpu_wren && hit;

  always_comb
  begin
    state_next = state;
    case (state)
      dcache_pkg::SEQ_IDLE:
        if (cached_req)
          state_next = dcache_pkg::SEQ_TAG_LOOKUP;
      dcache_pkg::SEQ_TAG_LOOKUP:
        // Stores always go through to memory
        if (hit && !cpu_wren)
          state_next = dcache_pkg::SEQ_IDLE;
        else
          state_next = dcache_pkg::SEQ_ISSUE;
      dcache_pkg::SEQ_ISSUE:
        if (issued_r && !mem_wait)
          state_next = cpu_wren ? dcache_pkg::SEQ_STORE_MISS : dcache_pkg::SEQ_LOAD_MISS;
      dcache_pkg::SEQ_STORE_MISS:
        if (hit || !mem_wait || timed_out)
          state_next = dcache_pkg::SEQ_IDLE;
      dcache_pkg::SEQ_LOAD_MISS:
        if (hit || timed_out)
          state_next = dcache_pkg::SEQ_IDLE;
      default:
        state_next = dcache_pkg::SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!resetn)
      state <= dcache_pkg::SEQ_IDLE;
    else
      state <= state_next;
  end

  // Marks the pulse cycle so issue holds without pulsing again
  always_ff @(posedge clk)
  begin
    if (!resetn)
      issued_r <= 1'b0;
    else
      issued_r <= (state == dcache_pkg::SEQ_ISSUE);
  end

  assign mem_en = (state == dcache_pkg::SEQ_ISSUE) && !issued_r;

  // Ones drain out while mem_wait stays low
  always_ff @(posedge clk)
  begin
    if (!resetn)
      timeout_sr <= '0;
    else if (state == dcache_pkg::SEQ_ISSUE)
      timeout_sr <= '1;
    else
      timeout_sr <= {mem_wait, timeout_sr[dcache_pkg::FILL_TIMEOUT-1:1]};
  end

  // A timed-out load keeps the core stalled and retries from idle
  always_comb
  begin
    case (state)
      dcache_pkg::SEQ_IDLE:       cached_wait = cached_req;
      dcache_pkg::SEQ_TAG_LOOKUP: cached_wait = !(hit && !cpu_wren);
      dcache_pkg::SEQ_ISSUE:      cached_wait = 1'b1;
      dcache_pkg::SEQ_STORE_MISS: cached_wait = mem_wait && !hit;
      dcache_pkg::SEQ_LOAD_MISS:  cached_wait = !hit;
      default:                    cached_wait = 1'b0;
    endcase
  end

  mem_en_single: assert property (
    @(posedge clk) disable iff (!resetn)
    mem_en |=> !mem_en
  )
  else $error("mem_en held for two cycles");

  idle_after_reset: assert property (
    @(posedge clk)
    !resetn |=> (state == dcache_pkg::SEQ_IDLE)
  )
  else $error("sequencer not idle after reset");

endmodule

`default_nettype wire

//--- rtl/uncached_path.sv
`default_nettype none

module uncached_path (
  input  wire logic                 clk,
  input  wire logic                 resetn,
  input  wire logic                 cpu_en,
  input  mem_map_pkg::addr_t        cpu_address,
  input  wire logic                 cached_wait,
  input  wire logic                 periph_wait,
  input  dcache_pkg::line_t         read_line,
  input  mem_map_pkg::word_t        periph_readdata,
  output logic                      periph_en,
  output mem_map_pkg::word_t        cpu_readdata,
  output logic                      cpu_wait
);

  logic uncached_req;
  logic uncached_r;
  dcache_pkg::word_sel_t word_sel_r;

  assign uncached_req = cpu_en && cpu_address[mem_map_pkg::UNCACHED_BIT];

  // Held for the whole peripheral access
  assign periph_en = uncached_req;

  // Region of the access seen last cycle
  always_ff @(posedge clk)
  begin
    if (!resetn)
      uncached_r <= 1'b0;
    else
      uncached_r <= uncached_req;
  end

  always_ff @(posedge clk)
  begin
    word_sel_r <= cpu_address[dcache_pkg::WORD_SEL_LSB +: dcache_pkg::WORD_SEL_W];
  end

  assign cpu_readdata = uncached_r ? periph_readdata : read_line[word_sel_r];

  // First peripheral cycle stalls before periph_wait can rise
  assign cpu_wait = cached_wait || (uncached_req && (!uncached_r || periph_wait));

  periph_en_held: assert property (
    @(posedge clk) disable iff (!resetn)
    (periph_en && cpu_wait) |=> periph_en
  )
  else $error("periph_en dropped before the access completed");

endmodule

`default_nettype wire

//--- rtl/dbus_frontend.sv
`default_nettype none

module dbus_frontend (
  input  wire logic                 clk,
  input  wire logic                 resetn,
  // Core data bus
  input  wire logic                 cpu_en,
  input  mem_map_pkg::addr_t        cpu_address,
  input  wire logic                 cpu_wren,
  input  mem_map_pkg::word_t        cpu_writedata,
  input  mem_map_pkg::byteen_t      cpu_byteen,
  output mem_map_pkg::word_t        cpu_readdata,
  output logic                      cpu_wait,
  // Memory requests
  output logic                      mem_en,
  output mem_map_pkg::addr_t        mem_address,
  output logic                      mem_wren,
  output mem_map_pkg::word_t        mem_writedata,
  output mem_map_pkg::byteen_t      mem_byteen,
  input  wire logic                 mem_wait,
  // Line fills
  input  wire logic                 fill_we,
  input  mem_map_pkg::addr_t        fill_address,
  input  dcache_pkg::line_t         fill_data,
  // Peripheral bus
  output logic                      periph_en,
  output mem_map_pkg::addr_t        periph_address,
  output logic                      periph_wren,
  output mem_map_pkg::word_t        periph_writedata,
  output mem_map_pkg::byteen_t      periph_byteen,
  input  mem_map_pkg::word_t        periph_readdata,
  input  wire logic                 periph_wait
);

  logic hit;
  dcache_pkg::line_t read_line;
  logic word_we;
  mem_map_pkg::word_t word_data;
  mem_map_pkg::byteen_t word_byteen;
  logic cached_wait;

  // Both buses see the core request as is
  assign mem_address = cpu_address;
  assign mem_wren = cpu_wren;
  assign mem_writedata = cpu_writedata;
  assign mem_byteen = cpu_byteen;

  assign periph_address = cpu_address;
  assign periph_wren = cpu_wren;
  assign periph_writedata = cpu_writedata;
  assign periph_byteen = cpu_byteen;

  dcache_array array_i (
    .clk            (clk),
    .resetn         (resetn),
    .lookup_address (cpu_address),
    .hit            (hit),
    .read_line      (read_line),
    .word_we        (word_we),
    .word_address   (cpu_address),
    .word_data      (word_data),
    .word_byteen    (word_byteen),
    .fill_we        (fill_we),
    .fill_address   (fill_address),
    .fill_data      (fill_data)
  );

  miss_sequencer seq_i (
    .clk           (clk),
    .resetn        (resetn),
    .cpu_en        (cpu_en),
    .cpu_wren      (cpu_wren),
    .cpu_address   (cpu_address),
    .cpu_writedata (cpu_writedata),
    .cpu_byteen    (cpu_byteen),
    .hit           (hit),
    .mem_en        (mem_en),
    .mem_wait      (mem_wait),
    .word_we       (word_we),
    .word_data     (word_data),
    .word_byteen   (word_byteen),
    .cached_wait   (cached_wait)
  );

  uncached_path uncached_i (
    .clk             (clk),
    .resetn          (resetn),
    .cpu_en          (cpu_en),
    .cpu_address     (cpu_address),
    .cached_wait     (cached_wait),
    .periph_wait     (periph_wait),
    .read_line       (read_line),
    .periph_readdata (periph_readdata),
    .periph_en       (periph_en),
    .cpu_readdata    (cpu_readdata),
    .cpu_wait        (cpu_wait)
  );

endmodule

`default_nettype wire

//--- sim/tb_dbus_frontend.sv
`default_nettype none

module tb_dbus_frontend;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_ACCESSES = 400;
  localparam int CLK_PERIOD = 8;
  localparam int DRIVE_DELAY = 1;

  logic clk = 1'b0;
  logic resetn;
  logic cpu_en;
  logic cpu_wren;
  mem_map_pkg::addr_t cpu_address;
  mem_map_pkg::word_t cpu_writedata;
  mem_map_pkg::byteen_t cpu_byteen;
  mem_map_pkg::word_t cpu_readdata;
  logic cpu_wait;
  logic mem_en;
  logic mem_wren;
  mem_map_pkg::addr_t mem_address;
  mem_map_pkg::word_t mem_writedata;
  mem_map_pkg::byteen_t mem_byteen;
  logic mem_wait;
  logic fill_we;
  mem_map_pkg::addr_t fill_address;
  dcache_pkg::line_t fill_data;
  logic periph_en;
  logic periph_wren;
  mem_map_pkg::addr_t periph_address;
  mem_map_pkg::word_t periph_writedata;
  mem_map_pkg::byteen_t periph_byteen;
  mem_map_pkg::word_t periph_readdata;
  logic periph_wait;

  integer seed = 32'h3e5f56ba;
  int mismatches = 0;
  int failures = 0;
  int request_errors = 0;
  int mem_pulses = 0;
  int withheld_fills = 0;

  // Memory and peripheral contents
  mem_map_pkg::word_t mem_words [mem_map_pkg::addr_t];
  mem_map_pkg::word_t periph_regs [8];
  // Resident tag per line with the valid flag on top
  logic [21:0] model_line [64];

  dbus_frontend dut_i (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic mem_map_pkg::word_t memory_word(input mem_map_pkg::addr_t a);
    // Untouched words read back a pattern of their own address
    return mem_words.exists(a) ? mem_words[a] : ({a[15:0], a[31:16]} ^ 32'h5ac3_93e1);
  endfunction

  function automatic mem_map_pkg::word_t merge_bytes(input mem_map_pkg::word_t old_word,
                                                      input mem_map_pkg::word_t new_word,
                                                      input mem_map_pkg::byteen_t be);
    mem_map_pkg::word_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  function automatic int pick_between(input int lo, input int hi);
    logic [31:0] r;
    r = $random(seed);
    return lo + int'(r % (hi - lo + 1));
  endfunction

  // Memory is busy 1 to 5 cycles and fills the line on loads only
  initial
  begin : memory_responder
    mem_map_pkg::addr_t line_base;
    logic is_store;
    logic withhold;
    logic retry_due;
    int busy;
    mem_wait = 1'b0;
    fill_we = 1'b0;
    fill_address = '0;
    fill_data = '0;
    retry_due = 1'b0;
    for (int i = 0; i < 64; i++)
      model_line[i] = '0;
    forever
    begin
      @(negedge clk);
      if (mem_en === 1'b1)
      begin
        mem_pulses++;
        if ({mem_wren, mem_byteen, mem_address, mem_writedata} !==
            {cpu_wren, cpu_byteen, cpu_address, cpu_writedata})
        begin
          $display("MISMATCH mem_request expected %h actual %h",
                   {cpu_wren, cpu_byteen, cpu_address, cpu_writedata},
                   {mem_wren, mem_byteen, mem_address, mem_writedata});
          request_errors++;
        end
        is_store = mem_wren;
        line_base = {mem_address[31:4], 4'h0};
        if (is_store)
          mem_words[mem_address] = merge_bytes(memory_word(mem_address), mem_writedata,
                                               mem_byteen);
        // An occasional load gets no fill but its retry always does
        withhold = !is_store && !retry_due && (pick_between(0, 5) == 0);
        retry_due = withhold;
        busy = pick_between(1, 5);
        @(posedge clk);
        #DRIVE_DELAY;
        mem_wait = 1'b1;
        repeat (busy - 1)
        begin
          @(posedge clk);
          #DRIVE_DELAY;
        end
        if (withhold)
          withheld_fills++;
        else if (!is_store)
        begin
          fill_address = line_base;
          for (int w = 0; w < 4; w++)
            fill_data[w] = memory_word(line_base + 32'(4 * w));
          fill_we = 1'b1;
          model_line[line_base[9:4]] = {1'b1, line_base[30:10]};
        end
        @(posedge clk);
        #DRIVE_DELAY;
        fill_we = 1'b0;
        mem_wait = 1'b0;
      end
    end
  end

  // Peripheral is busy 1 to 4 cycles and then answers from its register file
  initial
  begin : periph_responder
    int busy;
    logic [2:0] sel;
    periph_wait = 1'b0;
    periph_readdata = '0;
    for (int i = 0; i < 8; i++)
      periph_regs[i] = memory_word(32'h8000_0000 | 32'(i * 4));
    forever
    begin
      @(negedge clk);
      if (periph_en === 1'b1)
      begin
        if ({periph_wren, periph_byteen, periph_address, periph_writedata} !==
            {cpu_wren, cpu_byteen, cpu_address, cpu_writedata})
        begin
          $display("MISMATCH periph_request expected %h actual %h",
                   {cpu_wren, cpu_byteen, cpu_address, cpu_writedata},
                   {periph_wren, periph_byteen, periph_address, periph_writedata});
          request_errors++;
        end
        busy = pick_between(1, 4);
        sel = periph_address[4:2];
        @(posedge clk);
        #DRIVE_DELAY;
        periph_wait = 1'b1;
        repeat (busy)
        begin
          @(posedge clk);
          #DRIVE_DELAY;
        end
        if (periph_wren)
          periph_regs[sel] = merge_bytes(periph_regs[sel], periph_writedata, periph_byteen);
        else
          periph_readdata = periph_regs[sel];
        periph_wait = 1'b0;
        // Core completes at the next edge and drops the request
        while (periph_en === 1'b1)
          @(negedge clk);
      end
    end
  end

  // One core access held until cpu_wait is seen low
  task automatic run_access(input mem_map_pkg::addr_t address, input logic wren,
                            input mem_map_pkg::word_t wdata,
                            input mem_map_pkg::byteen_t byteen,
                            output mem_map_pkg::word_t rdata, output int cycles);
    logic uncached;
    uncached = address[mem_map_pkg::UNCACHED_BIT];
    cycles = 0;
    @(posedge clk);
    #DRIVE_DELAY;
    cpu_en = 1'b1;
    cpu_address = address;
    cpu_wren = wren;
    cpu_writedata = wdata;
    cpu_byteen = byteen;
    forever
    begin
      @(negedge clk);
      cycles++;
      if (periph_en !== uncached)
      begin
        $display("periph_en was %b during an access to %h", periph_en, address);
        failures++;
      end
      if (cpu_wait === 1'b0)
        break;
    end
    rdata = cpu_readdata;
    @(posedge clk);
    #DRIVE_DELAY;
    cpu_en = 1'b0;
  endtask

  initial
  begin : core_driver
    mem_map_pkg::addr_t address;
    mem_map_pkg::word_t wdata;
    mem_map_pkg::word_t expected;
    mem_map_pkg::word_t rdata;
    logic [31:0] bits;
    logic wren;
    logic uncached;
    logic expect_hit;
    int cycles;
    int pulses;
    int withheld;
    resetn = 1'b0;
    cpu_en = 1'b0;
    cpu_address = '0;
    cpu_wren = 1'b0;
    cpu_writedata = '0;
    cpu_byteen = '0;
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    resetn = 1'b1;
    @(negedge clk);
    if (mem_en !== 1'b0 || periph_en !== 1'b0 || cpu_wait !== 1'b0)
    begin
      $display("outputs not idle after reset: mem_en %b periph_en %b cpu_wait %b",
               mem_en, periph_en, cpu_wait);
      failures++;
    end

    for (int n = 0; n < N_ACCESSES; n++)
    begin
      bits = $random(seed);
      uncached = (pick_between(0, 9) < 3);
      // Few tags over few lines so hits and conflicts both happen
      address = uncached ? (32'h8000_0000 | (bits & 32'h0000_001c)) : (bits & 32'h0000_0c3c);
      wren = (pick_between(0, 9) < 4);
      wdata = $random(seed);
      expected = uncached ? periph_regs[address[4:2]] : memory_word(address);
      expect_hit = !uncached && !wren && (model_line[address[9:4]] == {1'b1, address[30:10]});
      pulses = mem_pulses;
      withheld = withheld_fills;
      run_access(address, wren, wdata, (bits[31:28] == 4'h0) ? 4'hf : bits[31:28],
                 rdata, cycles);
      pulses = mem_pulses - pulses;
      withheld = withheld_fills - withheld;

      if (!wren && rdata !== expected)
      begin
        $display("MISMATCH %s expected %h actual %h",
                 uncached ? "uncached_load" : "cached_load", expected, rdata);
        mismatches++;
      end
      if (uncached)
      begin
        if (pulses != 0)
        begin
          $display("uncached access to %h sent %0d requests to memory", address, pulses);
          failures++;
        end
      end
      else if (wren)
      begin
        if (pulses != 1)
        begin
          $display("MISMATCH store_requests expected 1 actual %0d", pulses);
          mismatches++;
        end
      end
      else if (expect_hit)
      begin
        if (cycles != 2)
        begin
          $display("MISMATCH hit_cycles expected 2 actual %0d", cycles);
          mismatches++;
        end
        if (pulses != 0)
        begin
          $display("load hit at %h still sent a request to memory", address);
          failures++;
        end
      end
      // A miss asks once plus once more per withheld fill
      else if (pulses != 1 + withheld)
      begin
        $display("MISMATCH miss_requests expected %0d actual %0d", 1 + withheld, pulses);
        mismatches++;
      end
    end

    @(posedge clk);
    $display("errors: %0d mismatches, %0d request errors, %0d other failures (%0d fills withheld)",
             mismatches, request_errors, failures, withheld_fills);
    if (mismatches + request_errors + failures == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // Bound of 30 cycles per access
  initial
  begin : watchdog
    #(N_ACCESSES * 30 * CLK_PERIOD);
    $display("timeout: the accesses did not complete within %0d ns",
             N_ACCESSES * 30 * CLK_PERIOD);
    $display("errors: %0d mismatches, %0d request errors, %0d other failures",
             mismatches, request_errors, failures + 1);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
rtl/mem_map_pkg.sv
rtl/dcache_pkg.sv
rtl/dcache_array.sv
rtl/miss_sequencer.sv
rtl/uncached_path.sv
rtl/dbus_frontend.sv
sim/tb_dbus_frontend.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the data-bus front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_dbus_frontend -f sources.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
  exit 0
fi
echo "simulation did not pass"
exit 1
